// ==== common/lsq_pkg.sv ====
/*
 * Load/store queue shared definitions
 * Widths, queue depths, pointer types and dispatch opcodes
 */
package lsq_pkg;

	//////////////////////////////////////////////////
	// Widths and depths
	//////////////////////////////////////////////////
	localparam int DATA_WIDTH    = 64;
	localparam int LQ_DEPTH      = 8;
	localparam int SQ_DEPTH      = 8;
	localparam int TAG_WIDTH     = 6;   // Physical register tag
	localparam int ROB_IDX_WIDTH = 5;
	localparam int LQ_IDX_WIDTH  = $clog2(LQ_DEPTH);
	localparam int SQ_IDX_WIDTH  = $clog2(SQ_DEPTH);

	//////////////////////////////////////////////////
	// Types
	//////////////////////////////////////////////////
	typedef logic [DATA_WIDTH-1:0]    data_t;      // Data word or address
	typedef logic [TAG_WIDTH-1:0]     tag_t;
	typedef logic [ROB_IDX_WIDTH-1:0] rob_idx_t;

	// Queue pointers carry one wrap bit above the entry index
	typedef logic [LQ_IDX_WIDTH:0] lq_ptr_t;
	typedef logic [SQ_IDX_WIDTH:0] sq_ptr_t;

	// Operation handed over at dispatch
	typedef enum logic [1:0] {
		mem_op_none  = 2'd0,
		mem_op_load  = 2'd1,
		mem_op_store = 2'd2
	} mem_op_e;

endpackage

// ==== store_queue/store_queue.sv ====
/*
 * Store queue
 * Circular buffer of stores with head, commit and tail pointers.
 * Committed stores at the head go to the memory issue logic in order
 */
`timescale 1ns/100ps

module store_queue import lsq_pkg::*; (
	input  logic    clock,
	input  logic    reset,
	input  logic    disp_valid,
	input  mem_op_e disp_op,
	input  data_t   disp_base,
	input  data_t   disp_offset,
	input  data_t   disp_store_data,
	input  logic    commit_store,
	input  logic    mispredict,
	input  logic    st_issue,
	output logic    sq_full,
	output sq_ptr_t sq_head,
	output sq_ptr_t sq_tail,
	output logic    st_pending,
	output data_t   st_addr,
	output data_t   st_data
);

	data_t   addr_q [SQ_DEPTH];   // Effective addresses
	data_t   data_q [SQ_DEPTH];
	sq_ptr_t commit_ptr;          // Oldest uncommitted store
	sq_ptr_t commit_next;
	logic    disp_store;
	logic    [SQ_IDX_WIDTH-1:0] head_idx;
	logic    [SQ_IDX_WIDTH-1:0] tail_idx;

	assign head_idx = sq_head[SQ_IDX_WIDTH-1:0];
	assign tail_idx = sq_tail[SQ_IDX_WIDTH-1:0];

	// A dispatch in the flush cycle belongs to the wrong path
	assign disp_store = disp_valid && (disp_op == mem_op_store) && !mispredict;

	// Commit only steps over stores that are in the queue
	assign commit_next = (commit_store && (commit_ptr != sq_tail)) ?
		sq_ptr_t'(commit_ptr + 1'b1) : commit_ptr;

	//////////////////////////////////////////////////
	// Pointers
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			sq_head    <= '0;
			commit_ptr <= '0;
			sq_tail    <= '0;
		end else begin
			commit_ptr <= commit_next;
			if (st_issue) begin
				sq_head <= sq_head + 1'b1;   // Write sent, entry free
			end
			if (mispredict) begin
				// Roll back over every uncommitted store
				sq_tail <= commit_next;
			end else if (disp_store) begin
				sq_tail <= sq_tail + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Entry storage
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (disp_store) begin
			addr_q[tail_idx] <= disp_base + disp_offset;
			data_q[tail_idx] <= disp_store_data;
		end
	end

	// Head is committed but not yet written
	assign st_pending = (sq_head != commit_ptr);
	assign st_addr    = addr_q[head_idx];
	assign st_data    = data_q[head_idx];

	// Same index, opposite wrap bit
	assign sq_full = (head_idx == tail_idx) &&
		(sq_head[SQ_IDX_WIDTH] != sq_tail[SQ_IDX_WIDTH]);

endmodule

// ==== load_queue/load_queue.sv ====
/*
 * Load queue
 * Holds loads in program order, waits for older stores to drain,
 * sends the head load to memory and broadcasts its data on the CDB
 */
`timescale 1ns/100ps

module load_queue import lsq_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     disp_valid,
	input  mem_op_e  disp_op,
	input  data_t    disp_base,
	input  data_t    disp_offset,
	input  tag_t     disp_dest_tag,
	input  rob_idx_t disp_rob_idx,
	input  sq_ptr_t  sq_head,
	input  sq_ptr_t  sq_tail,
	input  logic     mispredict,
	input  logic     ld_issue,
	input  logic     mem_resp_valid,
	input  data_t    mem_rdata,
	output logic     lq_full,
	output logic     ld_pending,
	output data_t    ld_addr,
	output logic     cdb_valid,
	output tag_t     cdb_tag,
	output data_t    cdb_data,
	output rob_idx_t cdb_rob_idx
);

	data_t    addr_q    [LQ_DEPTH];
	tag_t     tag_q     [LQ_DEPTH];
	rob_idx_t rob_q     [LQ_DEPTH];
	sq_ptr_t  sq_mark_q [LQ_DEPTH];   // Store tail seen at dispatch
	lq_ptr_t  head;
	lq_ptr_t  tail;
	logic     [LQ_IDX_WIDTH-1:0] head_idx;
	logic     [LQ_IDX_WIDTH-1:0] tail_idx;
	logic     head_issued;   // Head read sent, data not back yet
	logic     discard;       // Swallow response of a flushed read
	logic     disp_load;
	sq_ptr_t  older_stores;
	sq_ptr_t  sq_count;
	logic     head_eligible;

	assign head_idx  = head[LQ_IDX_WIDTH-1:0];
	assign tail_idx  = tail[LQ_IDX_WIDTH-1:0];
	assign disp_load = disp_valid && (disp_op == mem_op_load) && !mispredict;

	//////////////////////////////////////////////////
	// Store ordering check
	//////////////////////////////////////////////////
	// Distance from sq_head to the head load's mark. Once sq_head has
	// moved past the mark this distance exceeds the store count
	assign older_stores  = sq_mark_q[head_idx] - sq_head;
	assign sq_count      = sq_tail - sq_head;
	assign head_eligible = (older_stores == '0) || (older_stores > sq_count);

	assign ld_pending = (head != tail) && !head_issued && head_eligible;
	assign ld_addr    = addr_q[head_idx];
	assign lq_full    = (head_idx == tail_idx) &&
		(head[LQ_IDX_WIDTH] != tail[LQ_IDX_WIDTH]);

	//////////////////////////////////////////////////
	// Control
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			head        <= '0;
			tail        <= '0;
			head_issued <= 1'b0;
			discard     <= 1'b0;
			cdb_valid   <= 1'b0;
		end else begin
			cdb_valid <= 1'b0;
			if (mispredict) begin
				head        <= tail;   // Drop every load
				head_issued <= 1'b0;
				// A read already sent still returns data
				discard <= ((discard || head_issued) && !mem_resp_valid) || ld_issue;
			end else begin
				if (disp_load) begin
					tail <= tail + 1'b1;
				end
				if (ld_issue) begin
					head_issued <= 1'b1;
				end
				if (mem_resp_valid) begin
					if (discard) begin
						discard <= 1'b0;
					end else if (head_issued) begin
						cdb_valid   <= 1'b1;
						head        <= head + 1'b1;
						head_issued <= 1'b0;
					end
				end
			end
		end
	end

	// Entry storage and CDB payload
	always_ff @(posedge clock) begin
		if (disp_load) begin
			addr_q[tail_idx]    <= disp_base + disp_offset;
			tag_q[tail_idx]     <= disp_dest_tag;
			rob_q[tail_idx]     <= disp_rob_idx;
			sq_mark_q[tail_idx] <= sq_tail;
		end
		if (mem_resp_valid) begin
			cdb_data    <= mem_rdata;
			cdb_tag     <= tag_q[head_idx];
			cdb_rob_idx <= rob_q[head_idx];
		end
	end

endmodule

// ==== source/mem_issue.sv ====
/*
 * Memory issue
 * Picks the committed store or else the eligible load,
 * registers the request and tracks the single outstanding read
 */
`timescale 1ns/100ps

module mem_issue import lsq_pkg::*; (
	input  logic  clock,
	input  logic  reset,
	input  logic  st_pending,
	input  data_t st_addr,
	input  data_t st_data,
	input  logic  ld_pending,
	input  data_t ld_addr,
	input  logic  mem_resp_valid,
	output logic  st_issue,
	output logic  ld_issue,
	output logic  mem_req,
	output logic  mem_write,
	output data_t mem_addr,
	output data_t mem_wdata
);

	logic busy;       // Read outstanding
	logic mem_idle;

	// Memory frees up in the cycle its read data returns
	assign mem_idle = !busy || mem_resp_valid;

	// Stores win over loads
	assign st_issue = mem_idle && st_pending;
	assign ld_issue = mem_idle && ld_pending && !st_pending;

	always_ff @(posedge clock) begin
		if (reset) begin
			mem_req   <= 1'b0;
			mem_write <= 1'b0;
			busy      <= 1'b0;
		end else begin
			mem_req   <= st_issue || ld_issue;
			mem_write <= st_issue;
			if (ld_issue) begin
				busy <= 1'b1;
			end else if (mem_resp_valid) begin
				busy <= 1'b0;
			end
		end
	end

	// Request payload
	always_ff @(posedge clock) begin
		if (st_issue) begin
			mem_addr  <= st_addr;
			mem_wdata <= st_data;
		end else if (ld_issue) begin
			mem_addr <= ld_addr;
		end
	end

endmodule

// ==== source/lsq_top.sv ====
/*
 * Load/store queue top level
 * Connects the load queue, the store queue and the memory issue logic
 */
`timescale 1ns/100ps

module lsq_top import lsq_pkg::*; (
	input  logic     clock,
	input  logic     reset,
	input  logic     disp_valid,
	input  mem_op_e  disp_op,
	input  data_t    disp_base,
	input  data_t    disp_offset,
	input  data_t    disp_store_data,
	input  tag_t     disp_dest_tag,
	input  rob_idx_t disp_rob_idx,
	input  logic     commit_store,
	input  logic     mispredict,
	input  logic     mem_resp_valid,
	input  data_t    mem_rdata,
	output logic     lsq_full,
	output logic     mem_req,
	output logic     mem_write,
	output data_t    mem_addr,
	output data_t    mem_wdata,
	output logic     cdb_valid,
	output tag_t     cdb_tag,
	output data_t    cdb_data,
	output rob_idx_t cdb_rob_idx
);

	logic    lq_full;
	logic    sq_full;
	sq_ptr_t sq_head;
	sq_ptr_t sq_tail;
	logic    st_pending;
	data_t   st_addr;
	data_t   st_data;
	logic    st_issue;
	logic    ld_pending;
	data_t   ld_addr;
	logic    ld_issue;

	assign lsq_full = lq_full || sq_full;

	load_queue i_load_queue (
		.clock          (clock),
		.reset          (reset),
		.disp_valid     (disp_valid),
		.disp_op        (disp_op),
		.disp_base      (disp_base),
		.disp_offset    (disp_offset),
		.disp_dest_tag  (disp_dest_tag),
		.disp_rob_idx   (disp_rob_idx),
		.sq_head        (sq_head),
		.sq_tail        (sq_tail),
		.mispredict     (mispredict),
		.ld_issue       (ld_issue),
		.mem_resp_valid (mem_resp_valid),
		.mem_rdata      (mem_rdata),
		.lq_full        (lq_full),
		.ld_pending     (ld_pending),
		.ld_addr        (ld_addr),
		.cdb_valid      (cdb_valid),
		.cdb_tag        (cdb_tag),
		.cdb_data       (cdb_data),
		.cdb_rob_idx    (cdb_rob_idx)
	);

	store_queue i_store_queue (
		.clock           (clock),
		.reset           (reset),
		.disp_valid      (disp_valid),
		.disp_op         (disp_op),
		.disp_base       (disp_base),
		.disp_offset     (disp_offset),
		.disp_store_data (disp_store_data),
		.commit_store    (commit_store),
		.mispredict      (mispredict),
		.st_issue        (st_issue),
		.sq_full         (sq_full),
		.sq_head         (sq_head),
		.sq_tail         (sq_tail),
		.st_pending      (st_pending),
		.st_addr         (st_addr),
		.st_data         (st_data)
	);

	mem_issue i_mem_issue (
		.clock          (clock),
		.reset          (reset),
		.st_pending     (st_pending),
		.st_addr        (st_addr),
		.st_data        (st_data),
		.ld_pending     (ld_pending),
		.ld_addr        (ld_addr),
		.mem_resp_valid (mem_resp_valid),
		.st_issue       (st_issue),
		.ld_issue       (ld_issue),
		.mem_req        (mem_req),
		.mem_write      (mem_write),
		.mem_addr       (mem_addr),
		.mem_wdata      (mem_wdata)
	);

endmodule

// ==== tests/lsq_tb.sv ====
/*
 * Load/store queue testbench
 * Replays a command trace, models memory with random read latency
 * and checks memory writes and CDB broadcasts in order
 */
`timescale 1ns/100ps

module lsq_tb import lsq_pkg::*; ();

	logic     clock;
	logic     reset;
	logic     disp_valid;
	mem_op_e  disp_op;
	data_t    disp_base;
	data_t    disp_offset;
	data_t    disp_store_data;
	tag_t     disp_dest_tag;
	rob_idx_t disp_rob_idx;
	logic     commit_store;
	logic     mispredict;
	logic     mem_resp_valid;
	data_t    mem_rdata;
	logic     lsq_full;
	logic     mem_req;
	logic     mem_write;
	data_t    mem_addr;
	data_t    mem_wdata;
	logic     cdb_valid;
	tag_t     cdb_tag;
	data_t    cdb_data;
	rob_idx_t cdb_rob_idx;

	int    error_count = 0;
	int    check_count = 0;
	int    line_count = 0;
	bit    trace_loaded = 1'b0;
	byte   cmd_op [$];     // Stimulus commands in trace order
	data_t cmd_a [$];
	data_t cmd_b [$];
	data_t cmd_c [$];
	data_t cmd_d [$];
	data_t exp_wr_addr [$];
	data_t exp_wr_data [$];
	data_t exp_cdb_tag [$];
	data_t exp_cdb_data [$];
	data_t exp_cdb_rob [$];
	data_t shadow [data_t];   // Memory contents written so far

	lsq_top i_lsq_top (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////
	task automatic check_value(input string name, input data_t actual, input data_t expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic report_failure(input string what);
		error_count++;
		$display("At %0t: %s", $time, what);
	endtask

	task automatic drive_idle();
		disp_valid      = 1'b0;
		disp_op         = mem_op_none;
		disp_base       = '0;
		disp_offset     = '0;
		disp_store_data = '0;
		disp_dest_tag   = '0;
		disp_rob_idx    = '0;
		commit_store    = 1'b0;
		mispredict      = 1'b0;
	endtask

	task automatic dispatch(input mem_op_e op, input data_t base, input data_t offset,
			input data_t data, input tag_t tag, input rob_idx_t rob);
		disp_valid      = 1'b1;
		disp_op         = op;
		disp_base       = base;
		disp_offset     = offset;
		disp_store_data = data;
		disp_dest_tag   = tag;
		disp_rob_idx    = rob;
		@(negedge clock);
		drive_idle();
	endtask

	task automatic load_trace();
		int    fd;
		string line;
		byte   op;
		data_t a;
		data_t b;
		data_t c;
		data_t d;
		fd = $fopen("tests/lsq_trace.txt", "r");
		if (fd == 0) begin
			report_failure("cannot open the trace file tests/lsq_trace.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			op = line[0];
			if (line.len() == 0 || op == "#" || op == "\n") begin
				continue;
			end
			a = '0;
			b = '0;
			c = '0;
			d = '0;
			void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
			line_count++;
			case (op)
				"W": begin
					exp_wr_addr.push_back(a);
					exp_wr_data.push_back(b);
				end
				"D": begin
					exp_cdb_tag.push_back(a);
					exp_cdb_data.push_back(b);
					exp_cdb_rob.push_back(c);
				end
				default: begin
					cmd_op.push_back(op);
					cmd_a.push_back(a);
					cmd_b.push_back(b);
					cmd_c.push_back(c);
					cmd_d.push_back(d);
				end
			endcase
		end
		$fclose(fd);
	endtask

	//////////////////////////////////////////////////
	// Memory model and output checks
	//////////////////////////////////////////////////
	initial begin
		int    resp_wait;
		data_t resp_data;
		void'($urandom(33462));   // Read latencies come from this process
		resp_wait      = 0;
		resp_data      = '0;
		mem_resp_valid = 1'b0;
		mem_rdata      = '0;
		forever begin
			@(negedge clock);
			mem_resp_valid = 1'b0;
			if (resp_wait > 0) begin
				resp_wait--;
				if (resp_wait == 0) begin
					mem_resp_valid = 1'b1;
					mem_rdata      = resp_data;
				end
			end
			if (mem_req && (resp_wait > 0 || mem_resp_valid)) begin
				report_failure("memory request made while a read is outstanding");
			end
			if (mem_req && mem_write) begin
				shadow[mem_addr] = mem_wdata;
				if (exp_wr_addr.size() == 0) begin
					report_failure($sformatf("unexpected write of %h to %h", mem_wdata, mem_addr));
				end else begin
					check_value("mem_addr", mem_addr, exp_wr_addr.pop_front());
					check_value("mem_wdata", mem_wdata, exp_wr_data.pop_front());
				end
			end else if (mem_req) begin
				// Unwritten locations read as three times the address
				resp_data = shadow.exists(mem_addr) ? shadow[mem_addr] : mem_addr * 3;
				resp_wait = $urandom_range(4, 1);
			end
			if (cdb_valid) begin
				if (exp_cdb_tag.size() == 0) begin
					report_failure($sformatf("unexpected CDB broadcast for tag %h", cdb_tag));
				end else begin
					check_value("cdb_tag", data_t'(cdb_tag), exp_cdb_tag.pop_front());
					check_value("cdb_data", cdb_data, exp_cdb_data.pop_front());
					check_value("cdb_rob_idx", data_t'(cdb_rob_idx), exp_cdb_rob.pop_front());
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Trace replay
	//////////////////////////////////////////////////
	initial begin
		drive_idle();
		reset = 1'b1;
		load_trace();
		trace_loaded = 1'b1;
		repeat (3) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		check_value("mem_req", data_t'(mem_req), '0);   // Quiet after reset
		check_value("cdb_valid", data_t'(cdb_valid), '0);
		check_value("lsq_full", data_t'(lsq_full), '0);
		foreach (cmd_op[i]) begin
			case (cmd_op[i])
				"L": dispatch(mem_op_load, cmd_a[i], cmd_b[i], '0,
					tag_t'(cmd_c[i]), rob_idx_t'(cmd_d[i]));
				"S": dispatch(mem_op_store, cmd_a[i], cmd_b[i], cmd_c[i],
					'0, rob_idx_t'(cmd_d[i]));
				"C": begin
					commit_store = 1'b1;
					@(negedge clock);
					drive_idle();
				end
				"F": begin
					mispredict = 1'b1;
					@(negedge clock);
					drive_idle();
				end
				"I": repeat (int'(cmd_a[i])) @(negedge clock);
				"P": check_value("lsq_full", data_t'(lsq_full), cmd_a[i]);
				default: report_failure($sformatf("unknown trace command %c", cmd_op[i]));
			endcase
		end
		repeat (16) @(negedge clock);   // Drain late responses
		if (exp_wr_addr.size() != 0) begin
			report_failure($sformatf("%0d expected writes never seen", exp_wr_addr.size()));
		end
		if (exp_cdb_tag.size() != 0) begin
			report_failure($sformatf("%0d expected CDB results never seen", exp_cdb_tag.size()));
		end
		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	// Watchdog sized from the trace length
	initial begin
		wait (trace_loaded);
		repeat ((line_count + 1) * 40) @(posedge clock);
		$display("Timeout: trace did not finish after %0d cycles", (line_count + 1) * 40);
		$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== lsq_top.f ====
common/lsq_pkg.sv
store_queue/store_queue.sv
load_queue/load_queue.sv
source/mem_issue.sv
source/lsq_top.sv
tests/lsq_tb.sv

// ==== run_sim.sh ====
#!/bin/bash
# Builds the load/store queue testbench with Verilator and runs it.
# The run counts as passed only if the log holds the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 --top-module lsq_tb -f lsq_top.f -o lsq_sim \
	&& ./obj_dir/lsq_sim | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -q "^Result: PASSED$" sim.log \
	&& echo "Log check: pass line found" \
	|| { echo "Log check: pass line missing"; exit 1; }

// ==== tests/lsq_trace.txt ====
# One command per line, fields in hex
# L base offset tag rob | S base offset data rob | C commit | F flush | I cycles
# W addr data expected write | D tag data rob expected CDB | P expected lsq_full
# Store then load to the same address
S 1000 8 dead0001 1
L 0ff0 18 5 2
C
W 1008 dead0001
D 5 dead0001 2
I 10
# Load ahead of a younger uncommitted store
L 2000 40 6 3
S 2000 40 beef 4
I 8
D 6 60c0 3
C
W 2040 beef
I 10
# Committed stores drain in program order
S 3000 0 1111 5
S 2ff8 8 3333 6
L 3000 0 7 7
C
C
W 3000 1111
W 3000 3333
D 7 3333 7
I 10
# Flush keeps the committed store only
S 4000 0 aaaa 8
C
S 4000 8 bbbb 9
L 4000 0 8 a
F
I 10
L 4000 8 9 b
W 4000 aaaa
D 9 c018 b
I 10
# Flush while a read is in flight
L 5000 0 a c
F
I 10
# One blocked store and a full load queue
S 6000 0 cccc d
L 6000 0 20 10
L 6000 0 21 11
L 6000 0 22 12
L 6000 0 23 13
L 6000 0 24 14
L 6000 0 25 15
L 6000 0 26 16
L 6000 0 27 17
P 1
C
I 60
P 0
W 6000 cccc
D 20 cccc 10
D 21 cccc 11
D 22 cccc 12
D 23 cccc 13
D 24 cccc 14
D 25 cccc 15
D 26 cccc 16
D 27 cccc 17
I 8
